// File: build.f
+incdir+rtl
rtl/link_state_pkg.sv
rtl/phy_lane_pkg.sv
rtl/lane_ready_monitor.sv
rtl/ltssm_fsm.sv
rtl/ordered_set_gen.sv
rtl/rx_training_counter.sv
rtl/tx_lane_mux.sv
rtl/slink_ltssm_top.sv
test/ltssm_asserts.sv
test/tb_ltssm.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_ltssm
RTL_TOP   ?= slink_ltssm_top
FLIST     ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= All tests passed!

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: build
	@out=$$(./$(OBJ_DIR)/V$(TOP) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR)

// File: test/tb_ltssm.sv
`include "ltssm_config.svh"

module tb_ltssm;
  import link_state_pkg::*;
  import phy_lane_pkg::*;

  localparam int BYTES = `LTSSM_DATA_WIDTH / 8;
  localparam int WORDS = OS_LEN / BYTES;  // Cycles per ordered set
  localparam int W     = `LTSSM_DATA_WIDTH;
  localparam int CW    = `LTSSM_COUNT_WIDTH;

  logic          clk;
  logic          reset;
  logic          enable;
  logic          phy_clk_ready;
  lane_mask_t    phy_tx_ready;
  lane_mask_t    phy_rx_ready;
  active_code_t  active_lanes;
  logic [CW-1:0] ts1_tx_count;
  logic [CW-1:0] ts1_rx_count;
  logic [CW-1:0] ts2_tx_count;
  logic [CW-1:0] ts2_rx_count;
  logic [CW-1:0] switch_time;
  logic [CW-1:0] exit_time;
  lane_mask_t    rx_ts1_seen;
  lane_mask_t    rx_ts2_seen;
  lane_mask_t    rx_sds_seen;
  logic          enter_px_state;
  logic          link_active_req;
  lane_bus_t     link_data;
  logic          phy_clk_en;
  logic          use_phy_clk;
  lane_mask_t    phy_tx_en;
  lane_mask_t    phy_rx_en;
  logic          phy_rx_align;
  logic          deskew_enable;
  logic          link_wake_n;
  logic          effect_update;
  logic          in_px_state;
  logic          sds_sent;
  lane_bus_t     ltssm_data;
  ltssm_state_t  ltssm_state;

  logic          early_ts2;
  int            sds_count;
  int            effect_count;

  slink_ltssm_top u_slink_ltssm_top (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // ------------------------------
  // Checks and helpers
  task automatic check(input string name, input logic [63:0] actual,
                       input logic [63:0] expected);
    if (actual !== expected) begin
      $display("ERROR at %0t: %s is %h, expected %h", $time, name, actual, expected);
      $display("Test failures found");
      $fatal(1);
    end
  endtask

  task automatic give_up(input string what);
    $display("Timeout at %0t: %s", $time, what);
    $display("Test failures found");
    $fatal(1);
  endtask

  function automatic lane_mask_t mask_of(input active_code_t code);
    lane_mask_t m;
    for (int i = 0; i < `LTSSM_NUM_LANES; i++) m[i] = (i < (1 << code));
    return m;
  endfunction

  // Word a lane should carry in a given state and word of the set
  function automatic lane_data_t set_word(input ltssm_state_t st, input int wi);
    lane_data_t d;
    logic first;
    d = '0;
    for (int b = 0; b < BYTES; b++) begin
      first = (wi == 0) && (b == 0);
      case (st)
        P0_TS1:  d[8*b +: 8] = first ? TSX_BYTE0 : TS1_BYTEX;
        P0_TS2:  d[8*b +: 8] = first ? TSX_BYTE0 : TS2_BYTEX;
        P0_SDS:  d[8*b +: 8] = first ? SDS_BYTE0 : SDS_BYTEX;
        default: d[8*b +: 8] = 8'h00;
      endcase
    end
    return d;
  endfunction

  task automatic step();
    @(posedge clk);
    #1;
  endtask

  task automatic wait_state(input ltssm_state_t st, input int limit, input string what);
    int n;
    n = 0;
    @(negedge clk);
    while (ltssm_state != st) begin
      n++;
      if (n > limit) give_up(what);
      @(negedge clk);
    end
  endtask

  // which 0 waits for in_px_state high, 1 for link_wake_n low
  task automatic wait_flag(input int which, input int limit, input string what);
    int n;
    n = 0;
    @(negedge clk);
    while ((which == 0) ? !in_px_state : link_wake_n) begin
      n++;
      if (n > limit) give_up(what);
      @(negedge clk);
    end
  endtask

  task automatic pick_settings();
    active_lanes = active_code_t'($urandom_range(0, 2));
    ts1_tx_count = CW'($urandom_range(0, 3));
    ts1_rx_count = CW'($urandom_range(1, 3));
    ts2_tx_count = CW'($urandom_range(0, 3));
    ts2_rx_count = CW'($urandom_range(1, 3));
    switch_time  = CW'($urandom_range(0, 4));
    exit_time    = CW'($urandom_range(0, 4));
    early_ts2    = ($urandom_range(0, 3) == 0);
    sds_count    = 0;
    effect_count = 0;
  endtask

  // ------------------------------
  // PHY model
  initial begin
    int clk_dly;
    int lane_dly;
    int word;
    phy_clk_ready = 1'b0;
    phy_tx_ready  = '0;
    phy_rx_ready  = '0;
    rx_ts1_seen   = '0;
    rx_ts2_seen   = '0;
    rx_sds_seen   = '0;
    link_data     = '0;
    clk_dly       = 3;
    lane_dly      = 3;
    word          = 0;
    forever begin
      step();
      link_data = lane_bus_t'({$urandom, $urandom});
      if (!phy_clk_en) begin
        phy_clk_ready = 1'b0;
        clk_dly       = $urandom_range(0, 7);
      end else if (clk_dly == 0) phy_clk_ready = 1'b1;
      else clk_dly--;
      if (phy_tx_en == '0) begin
        phy_tx_ready = '0;
        phy_rx_ready = '0;
        lane_dly     = $urandom_range(0, 9);
      end else if (lane_dly == 0) begin
        phy_tx_ready = phy_tx_en;
        phy_rx_ready = phy_rx_en;
      end else lane_dly--;
      // One seen flag per ordered set from the far end
      rx_ts1_seen = (ltssm_state == P0_TS1 && word == 0) ? '1 : '0;
      rx_ts2_seen = ((ltssm_state == P0_TS2 || (ltssm_state == P0_TS1 && early_ts2))
                     && word == 0) ? '1 : '0;
      if (ltssm_state inside {P0_TS1, P0_TS2, P0_SDS}) word = (word + 1) % WORDS;
      else word = 0;
    end
  end

  // ------------------------------
  // Reference model and per-cycle checks
  ltssm_state_t prev_state;
  lane_bus_t    prev_link;
  lane_mask_t   prev_mask;
  int           prev_wi;
  int           mon_wi;
  int           run_len;

  initial begin
    prev_state = IDLE;
    prev_link  = '0;
    prev_mask  = '0;
    prev_wi    = 0;
    mon_wi     = 0;
    run_len    = 0;
  end

  always @(negedge clk) begin
    lane_bus_t  exp_data;
    lane_mask_t m;
    int         idx;
    int         min_len;
    if (!reset) begin
      idx = (ltssm_state inside {P0_TS1, P0_TS2, P0_SDS}) ? mon_wi : 0;
      for (int i = 0; i < `LTSSM_NUM_LANES; i++) begin
        if (!prev_mask[i]) exp_data[i*W +: W] = '0;
        else if (prev_state inside {P0, P0_EXIT}) exp_data[i*W +: W] = prev_link[i*W +: W];
        else exp_data[i*W +: W] = set_word(prev_state, prev_wi);
      end
      check("ltssm_data", ltssm_data, exp_data);
      check("in_px_state", in_px_state, prev_state == P1);
      check("use_phy_clk", use_phy_clk, !(ltssm_state inside {IDLE, WAIT_CLK}));
      m = mask_of(active_lanes);
      if (ltssm_state inside {IDLE, WAIT_CLK, P1}) begin
        check("phy_tx_en", phy_tx_en, 0);
        check("phy_rx_en", phy_rx_en, 0);
      end
      if (ltssm_state inside {P0_TS1, P0_TS2, P0_SDS, P0, P0_EXIT, P1_EXIT}) begin
        check("phy_tx_en", phy_tx_en, m);
        check("phy_rx_en", phy_rx_en, m);
      end
      if (sds_sent) begin
        check("sds_sent on last SDS word",
              (ltssm_state == P0_SDS) && (idx == WORDS - 1), 1);
        sds_count++;
      end
      if (effect_update) effect_count++;

      // Training states last whole sets
      if (ltssm_state != prev_state && prev_state inside {P0_TS1, P0_TS2, P0_SDS}) begin
        if (ltssm_state != IDLE) begin  // Losing enable cuts a set short
          check("training run in sets", run_len % WORDS, 0);
          min_len = WORDS;
          if (prev_state == P0_TS1 && !early_ts2) min_len = (ts1_tx_count + 1) * WORDS;
          if (prev_state == P0_TS2) min_len = (ts2_tx_count + 1) * WORDS;
          check("training run too short", run_len < min_len, 0);
          if (prev_state == P0_SDS) check("SDS run length", run_len, WORDS);
        end
      end
      if (prev_state == P0_EXIT && ltssm_state == P1)
        check("P0_EXIT run length", run_len, exit_time + 1);
      if (prev_state == SWITCH && ltssm_state == P0_TS1)
        check("SWITCH run too short", run_len < switch_time + 1, 0);
      run_len = (ltssm_state == prev_state) ? run_len + 1 : 1;

      mon_wi     = (ltssm_state inside {P0_TS1, P0_TS2, P0_SDS}) ? (idx + 1) % WORDS : 0;
      prev_wi    = idx;
      prev_state = ltssm_state;
      prev_link  = link_data;
      prev_mask  = m;
    end
  end

  // ------------------------------
  // Main sequence
  initial begin
    void'($urandom(80069));
    reset           = 1'b1;
    enable          = 1'b0;
    enter_px_state  = 1'b0;
    link_active_req = 1'b0;
    pick_settings();
    repeat (3) @(posedge clk);
    #1;
    reset = 1'b0;

    @(negedge clk);
    check("phy_clk_en", phy_clk_en, 0);
    check("phy_tx_en", phy_tx_en, 0);
    check("phy_rx_en", phy_rx_en, 0);
    check("phy_rx_align", phy_rx_align, 0);
    check("deskew_enable", deskew_enable, 0);
    check("sds_sent", sds_sent, 0);
    check("effect_update", effect_update, 0);
    check("in_px_state", in_px_state, 0);
    check("link_wake_n", link_wake_n, 1);
    check("ltssm_state", ltssm_state, IDLE);
    check("ltssm_data", ltssm_data, 0);

    for (int round = 0; round < 4; round++) begin
      step();
      pick_settings();
      enable = 1'b1;
      wait_state(P0, 3000, "link never reached P0 after bring-up");
      check("sds_sent pulses", sds_count, 1);
      repeat ($urandom_range(4, 30)) step();
      enter_px_state = 1'b1;
      step();
      enter_px_state = 1'b0;
      wait_flag(0, 200, "in_px_state never went high");
      check("effect_update pulses", effect_count, 1);
      check("phy_tx_en in P1", phy_tx_en, 0);
      repeat ($urandom_range(0, 10)) step();
      link_active_req = 1'b1;
      step();
      link_active_req = 1'b0;
      wait_flag(1, 50, "link_wake_n never went low");
      wait_state(P0, 3000, "link never returned to P0 after P1");
      check("sds_sent pulses", sds_count, 2);

      // Drop enable from wherever a fresh bring-up has got to
      step();
      enable = 1'b0;
      wait_state(IDLE, 20, "controller did not go idle after enable dropped");
      repeat (5) step();
      pick_settings();
      enable = 1'b1;
      repeat ($urandom_range(5, 90)) step();
      enable = 1'b0;
      repeat (3) step();
      wait_state(IDLE, 20, "controller did not go idle after enable dropped");
      @(negedge clk);
      check("phy_clk_en after drop", phy_clk_en, 0);
      repeat (5) step();
    end

    $display("All tests passed!");
    $finish;
  end

endmodule

// File: test/ltssm_asserts.sv
module ltssm_asserts (
  input logic                         clk,
  input logic                         reset,
  input logic                         sds_sent,
  input logic                         effect_update,
  input logic                         phy_clk_en,
  input logic                         lanes_on,
  input logic                         rx_align,
  input link_state_pkg::ltssm_state_t state
);
  import link_state_pkg::*;

  // ------------------------------
  // Single cycle pulses
  assert property (@(posedge clk) disable iff (reset) sds_sent |=> !sds_sent)
    else $error("sds_sent high for two cycles");
  assert property (@(posedge clk) disable iff (reset) effect_update |=> !effect_update)
    else $error("effect_update high for two cycles");

  // Lanes need the PHY clock
  assert property (@(posedge clk) disable iff (reset) lanes_on |-> phy_clk_en)
    else $error("lanes_on without phy_clk_en");

  assert property (@(posedge clk) disable iff (reset)
                   rx_align |-> (state inside {P0_TS1, P0_TS2, P0_SDS}))
    else $error("rx_align outside training");

endmodule

bind ltssm_fsm ltssm_asserts u_ltssm_asserts (.*);

// File: rtl/slink_ltssm_top.sv
`include "ltssm_config.svh"

module slink_ltssm_top (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          enable,
  input  logic                          phy_clk_ready,
  input  phy_lane_pkg::lane_mask_t      phy_tx_ready,
  input  phy_lane_pkg::lane_mask_t      phy_rx_ready,
  input  phy_lane_pkg::active_code_t    active_lanes,
  input  logic [`LTSSM_COUNT_WIDTH-1:0] ts1_tx_count,
  input  logic [`LTSSM_COUNT_WIDTH-1:0] ts1_rx_count,
  input  logic [`LTSSM_COUNT_WIDTH-1:0] ts2_tx_count,
  input  logic [`LTSSM_COUNT_WIDTH-1:0] ts2_rx_count,
  input  logic [`LTSSM_COUNT_WIDTH-1:0] switch_time,
  input  logic [`LTSSM_COUNT_WIDTH-1:0] exit_time,
  input  phy_lane_pkg::lane_mask_t      rx_ts1_seen,
  input  phy_lane_pkg::lane_mask_t      rx_ts2_seen,
  input  phy_lane_pkg::lane_mask_t      rx_sds_seen,
  input  logic                          enter_px_state,
  input  logic                          link_active_req,
  input  phy_lane_pkg::lane_bus_t       link_data,
  output logic                          phy_clk_en,
  output logic                          use_phy_clk,
  output phy_lane_pkg::lane_mask_t      phy_tx_en,
  output phy_lane_pkg::lane_mask_t      phy_rx_en,
  output logic                          phy_rx_align,
  output logic                          deskew_enable,
  output logic                          link_wake_n,
  output logic                          effect_update,
  output logic                          in_px_state,
  output logic                          sds_sent,
  output phy_lane_pkg::lane_bus_t       ltssm_data,
  output link_state_pkg::ltssm_state_t  ltssm_state
);
  import phy_lane_pkg::*;

  logic                          enable_sync;
  logic                          clk_ready_sync;
  logic                          all_ready;
  lane_mask_t                    lane_active;
  logic                          lanes_on;
  logic                          os_end;
  lane_data_t                    pattern;
  logic [`LTSSM_COUNT_WIDTH-1:0] ts1_count;
  logic [`LTSSM_COUNT_WIDTH-1:0] ts2_count;
  logic                          sds_seen;

  lane_ready_monitor u_lane_ready_monitor (
    .clk            (clk),
    .reset          (reset),
    .enable         (enable),
    .phy_clk_ready  (phy_clk_ready),
    .phy_tx_ready   (phy_tx_ready),
    .phy_rx_ready   (phy_rx_ready),
    .active_lanes   (active_lanes),
    .enable_sync    (enable_sync),
    .clk_ready_sync (clk_ready_sync),
    .all_ready      (all_ready),
    .lane_active    (lane_active)
  );

  ltssm_fsm u_ltssm_fsm (
    .clk             (clk),
    .reset           (reset),
    .enable_sync     (enable_sync),
    .clk_ready_sync  (clk_ready_sync),
    .all_ready       (all_ready),
    .os_end          (os_end),
    .sds_seen        (sds_seen),
    .ts1_count       (ts1_count),
    .ts2_count       (ts2_count),
    .ts1_tx_count    (ts1_tx_count),
    .ts1_rx_count    (ts1_rx_count),
    .ts2_tx_count    (ts2_tx_count),
    .ts2_rx_count    (ts2_rx_count),
    .switch_time     (switch_time),
    .exit_time       (exit_time),
    .enter_px_state  (enter_px_state),
    .link_active_req (link_active_req),
    .state           (ltssm_state),
    .phy_clk_en      (phy_clk_en),
    .use_phy_clk     (use_phy_clk),
    .lanes_on        (lanes_on),
    .rx_align        (phy_rx_align),
    .deskew_enable   (deskew_enable),
    .link_wake_n     (link_wake_n),
    .effect_update   (effect_update),
    .in_px_state     (in_px_state),
    .sds_sent        (sds_sent)
  );

  ordered_set_gen u_ordered_set_gen (
    .clk     (clk),
    .reset   (reset),
    .state   (ltssm_state),
    .os_end  (os_end),
    .pattern (pattern)
  );

  rx_training_counter u_rx_training_counter (
    .clk         (clk),
    .reset       (reset),
    .state       (ltssm_state),
    .rx_ts1_seen (rx_ts1_seen),
    .rx_ts2_seen (rx_ts2_seen),
    .rx_sds_seen (rx_sds_seen),
    .ts1_count   (ts1_count),
    .ts2_count   (ts2_count),
    .sds_seen    (sds_seen)
  );

  tx_lane_mux u_tx_lane_mux (
    .clk         (clk),
    .reset       (reset),
    .state       (ltssm_state),
    .lane_active (lane_active),
    .pattern     (pattern),
    .link_data   (link_data),
    .ltssm_data  (ltssm_data)
  );

  // ------------------------------
  // Lane enables follow the active mask
  assign phy_tx_en = lane_active & {`LTSSM_NUM_LANES{lanes_on}};
  assign phy_rx_en = lane_active & {`LTSSM_NUM_LANES{lanes_on}};

endmodule

// File: rtl/tx_lane_mux.sv
`include "ltssm_config.svh"

module tx_lane_mux (
  input  logic                         clk,
  input  logic                         reset,
  input  link_state_pkg::ltssm_state_t state,
  input  phy_lane_pkg::lane_mask_t     lane_active,
  input  phy_lane_pkg::lane_data_t     pattern,
  input  phy_lane_pkg::lane_bus_t      link_data,
  output phy_lane_pkg::lane_bus_t      ltssm_data
);
  import link_state_pkg::*;
  import phy_lane_pkg::*;

  localparam int W = `LTSSM_DATA_WIDTH;

  lane_bus_t data_sel;
  logic      pass_link;

  assign pass_link = (state == P0) || (state == P0_EXIT);

  for (genvar i = 0; i < `LTSSM_NUM_LANES; i++) begin : g_lane
    assign data_sel[i*W +: W] = !lane_active[i] ? {W{1'b0}} :
                                pass_link       ? link_data[i*W +: W] : pattern;
  end

  // Output register toward the PHY
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      ltssm_data <= '0;
    end else begin
      ltssm_data <= data_sel;
    end
  end

endmodule

// File: rtl/rx_training_counter.sv
`include "ltssm_config.svh"

module rx_training_counter (
  input  logic                          clk,
  input  logic                          reset,
  input  link_state_pkg::ltssm_state_t  state,
  input  phy_lane_pkg::lane_mask_t      rx_ts1_seen,
  input  phy_lane_pkg::lane_mask_t      rx_ts2_seen,
  input  phy_lane_pkg::lane_mask_t      rx_sds_seen,
  output logic [`LTSSM_COUNT_WIDTH-1:0] ts1_count,
  output logic [`LTSSM_COUNT_WIDTH-1:0] ts2_count,
  output logic                          sds_seen
);
  import link_state_pkg::*;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      ts1_count <= '0;
      ts2_count <= '0;
      sds_seen  <= 1'b0;
    end else begin
      // Every lane must agree, counts saturate
      if (state != P0_TS1) begin
        ts1_count <= '0;
      end else if (&rx_ts1_seen && !(&ts1_count)) begin
        ts1_count <= ts1_count + 1'b1;
      end

      if (!(state inside {P0_TS1, P0_TS2})) begin
        ts2_count <= '0;
      end else if (&rx_ts2_seen && !(&ts2_count)) begin
        ts2_count <= ts2_count + 1'b1;
      end

      if (state == P0_TS1) begin
        sds_seen <= 1'b0;
      end else if (state == P0_TS2 && rx_sds_seen[0]) begin
        sds_seen <= 1'b1;  // Lane 0 only
      end
    end
  end

endmodule

// File: rtl/ordered_set_gen.sv
`include "ltssm_config.svh"

module ordered_set_gen (
  input  logic                         clk,
  input  logic                         reset,
  input  link_state_pkg::ltssm_state_t state,
  output logic                         os_end,
  output phy_lane_pkg::lane_data_t     pattern
);
  import link_state_pkg::*;

  localparam int               BYTES = `LTSSM_DATA_WIDTH / 8;
  localparam int               CNT_W = $clog2(OS_LEN);
  localparam logic [CNT_W-1:0] STEP  = CNT_W'(BYTES);
  localparam logic [CNT_W-1:0] LAST  = CNT_W'(OS_LEN - BYTES);

  logic [CNT_W-1:0] byte_cnt;
  logic             training;
  logic             first_word;

  assign training   = state inside {P0_TS1, P0_TS2, P0_SDS};
  assign first_word = (byte_cnt == '0);
  assign os_end     = (byte_cnt == LAST);  // Count sits at zero outside training

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      byte_cnt <= '0;
    end else if (!training || os_end) begin
      byte_cnt <= '0;
    end else begin
      byte_cnt <= byte_cnt + STEP;
    end
  end

  // Byte 0 of the word goes on the wire first
  always_comb begin
    pattern = '0;
    for (int b = 0; b < BYTES; b++) begin
      case (state)
        P0_TS1:  pattern[8*b +: 8] = (first_word && b == 0) ? TSX_BYTE0 : TS1_BYTEX;
        P0_TS2:  pattern[8*b +: 8] = (first_word && b == 0) ? TSX_BYTE0 : TS2_BYTEX;
        P0_SDS:  pattern[8*b +: 8] = (first_word && b == 0) ? SDS_BYTE0 : SDS_BYTEX;
        default: pattern[8*b +: 8] = 8'h00;
      endcase
    end
  end

endmodule

// File: rtl/ltssm_fsm.sv
`include "ltssm_config.svh"

module ltssm_fsm (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          enable_sync,
  input  logic                          clk_ready_sync,
  input  logic                          all_ready,
  input  logic                          os_end,
  input  logic                          sds_seen,
  input  logic [`LTSSM_COUNT_WIDTH-1:0] ts1_count,
  input  logic [`LTSSM_COUNT_WIDTH-1:0] ts2_count,
  input  logic [`LTSSM_COUNT_WIDTH-1:0] ts1_tx_count,
  input  logic [`LTSSM_COUNT_WIDTH-1:0] ts1_rx_count,
  input  logic [`LTSSM_COUNT_WIDTH-1:0] ts2_tx_count,
  input  logic [`LTSSM_COUNT_WIDTH-1:0] ts2_rx_count,
  input  logic [`LTSSM_COUNT_WIDTH-1:0] switch_time,
  input  logic [`LTSSM_COUNT_WIDTH-1:0] exit_time,
  input  logic                          enter_px_state,
  input  logic                          link_active_req,
  output link_state_pkg::ltssm_state_t  state,
  output logic                          phy_clk_en,
  output logic                          use_phy_clk,
  output logic                          lanes_on,
  output logic                          rx_align,
  output logic                          deskew_enable,
  output logic                          link_wake_n,
  output logic                          effect_update,
  output logic                          in_px_state,
  output logic                          sds_sent
);
  import link_state_pkg::*;

  ltssm_state_t                  next_state;
  logic [`LTSSM_COUNT_WIDTH-1:0] count;
  logic [`LTSSM_COUNT_WIDTH-1:0] count_in;
  logic                          use_phy_clk_in;
  logic                          phy_clk_en_in;
  logic                          lanes_on_in;
  logic                          deskew_in;
  logic                          wake_n_in;
  logic                          effect_in;
  logic                          ts2_started;

  assign ts2_started = |ts2_count;  // Far end has moved on to TS2

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state         <= IDLE;
      count         <= '0;
      use_phy_clk   <= 1'b0;
      phy_clk_en    <= 1'b0;
      lanes_on      <= 1'b0;
      rx_align      <= 1'b0;
      deskew_enable <= 1'b0;
      link_wake_n   <= 1'b1;
      effect_update <= 1'b0;
      in_px_state   <= 1'b0;
    end else begin
      state         <= next_state;
      count         <= count_in;
      use_phy_clk   <= use_phy_clk_in;
      phy_clk_en    <= phy_clk_en_in;
      lanes_on      <= lanes_on_in;
      rx_align      <= (next_state == P0_TS1);  // Align only while sending TS1
      deskew_enable <= deskew_in;
      link_wake_n   <= wake_n_in;
      effect_update <= effect_in;
      in_px_state   <= (state == P1);
    end
  end

  always_comb begin
    next_state     = state;
    count_in       = count;
    use_phy_clk_in = use_phy_clk;
    phy_clk_en_in  = phy_clk_en;
    lanes_on_in    = lanes_on;
    deskew_in      = deskew_enable;
    wake_n_in      = 1'b0;
    effect_in      = 1'b0;

    case (state)
      // ------------------------------
      // Bring-up
      IDLE: begin
        wake_n_in     = 1'b1;
        phy_clk_en_in = 1'b0;
        lanes_on_in   = 1'b0;
        count_in      = '0;
        if (enable_sync) begin
          phy_clk_en_in = 1'b1;
          wake_n_in     = 1'b0;
          deskew_in     = 1'b0;
          next_state    = WAIT_CLK;
        end
      end
      WAIT_CLK: begin
        deskew_in = 1'b0;
        count_in  = '0;
        if (clk_ready_sync) begin
          use_phy_clk_in = 1'b1;
          next_state     = SWITCH;
        end
      end
      SWITCH: begin
        deskew_in = 1'b0;
        if (count == switch_time) begin
          lanes_on_in = 1'b1;  // Then wait on the PHY for as long as it takes
          if (all_ready) begin
            count_in   = '0;
            next_state = P0_TS1;
          end
        end else begin
          count_in = count + 1'b1;
        end
      end
      // ------------------------------
      // Training, timer counts whole ordered sets
      P0_TS1: begin
        deskew_in = 1'b1;
        if (os_end) begin
          if ((count == ts1_tx_count) || ts2_started) begin
            if ((ts1_count >= ts1_rx_count) || ts2_started) begin
              count_in   = '0;
              next_state = P0_TS2;
            end
          end else begin
            count_in = count + 1'b1;
          end
        end
      end
      P0_TS2: begin
        if (os_end) begin
          if ((count == ts2_tx_count) || sds_seen) begin
            if ((ts2_count >= ts2_rx_count) || sds_seen) begin
              count_in   = '0;
              next_state = P0_SDS;
            end
          end else begin
            count_in = count + 1'b1;
          end
        end
      end
      P0_SDS: begin
        if (os_end) begin
          next_state = P0;
        end
      end
      // ------------------------------
      // Active and low power
      P0: begin
        wake_n_in = 1'b1;
        if (enter_px_state) begin
          count_in   = '0;
          next_state = P0_EXIT;
        end
      end
      P0_EXIT: begin
        wake_n_in = 1'b1;
        if (count == exit_time) begin
          lanes_on_in = 1'b0;
          deskew_in   = 1'b0;
          effect_in   = 1'b1;
          count_in    = '0;
          next_state  = P1;
        end else begin
          count_in = count + 1'b1;
        end
      end
      P1: begin
        wake_n_in = 1'b1;
        if (link_active_req) begin
          lanes_on_in = 1'b1;
          deskew_in   = 1'b1;
          wake_n_in   = 1'b0;
          next_state  = P1_EXIT;
        end
      end
      P1_EXIT: begin
        if (all_ready) begin
          count_in   = '0;
          next_state = P0_TS1;
        end
      end
      default: begin
        next_state = IDLE;
      end
    endcase

    // Losing enable wins over everything
    if (!enable_sync) begin
      use_phy_clk_in = 1'b0;
      lanes_on_in    = 1'b0;
      deskew_in      = 1'b0;
      next_state     = IDLE;
    end
  end

  assign sds_sent = (state == P0_SDS) && (next_state == P0);  // Last word of the SDS set

endmodule

// File: rtl/lane_ready_monitor.sv
`include "ltssm_config.svh"

module lane_ready_monitor (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       enable,
  input  logic                       phy_clk_ready,
  input  phy_lane_pkg::lane_mask_t   phy_tx_ready,
  input  phy_lane_pkg::lane_mask_t   phy_rx_ready,
  input  phy_lane_pkg::active_code_t active_lanes,
  output logic                       enable_sync,
  output logic                       clk_ready_sync,
  output logic                       all_ready,
  output phy_lane_pkg::lane_mask_t   lane_active
);
  import phy_lane_pkg::*;

  localparam int SYNC_W = 2 + 2 * `LTSSM_NUM_LANES;

  logic [SYNC_W-1:0] sync_ff1;
  logic [SYNC_W-1:0] sync_ff2;
  lane_mask_t        tx_ready_sync;
  lane_mask_t        rx_ready_sync;

  // Two flop synchroniser on every asynchronous status bit
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      sync_ff1 <= '0;
      sync_ff2 <= '0;
    end else begin
      sync_ff1 <= {enable, phy_clk_ready, phy_tx_ready, phy_rx_ready};
      sync_ff2 <= sync_ff1;
    end
  end

  assign {enable_sync, clk_ready_sync, tx_ready_sync, rx_ready_sync} = sync_ff2;

  always_comb begin
    for (int i = 0; i < `LTSSM_NUM_LANES; i++) begin
      lane_active[i] = i < (1 << active_lanes);
    end
  end

  // Inactive lanes must also report not ready
  assign all_ready = (tx_ready_sync == lane_active) && (rx_ready_sync == lane_active);

endmodule

// File: rtl/phy_lane_pkg.sv
`include "ltssm_config.svh"

package phy_lane_pkg;

  // One bit per lane
  typedef logic [`LTSSM_NUM_LANES-1:0] lane_mask_t;

  // One lane's word
  typedef logic [`LTSSM_DATA_WIDTH-1:0] lane_data_t;

  // All lanes, lane 0 in the low bits
  typedef logic [`LTSSM_NUM_LANES*`LTSSM_DATA_WIDTH-1:0] lane_bus_t;

  // Code n enables lanes below 2**n
  typedef logic [1:0] active_code_t;

endpackage

// File: rtl/link_state_pkg.sv
package link_state_pkg;

  // Controller states, encoded as on the ltssm_state debug port
  typedef enum logic [3:0] {
    IDLE     = 4'd0,
    WAIT_CLK = 4'd1,
    SWITCH   = 4'd2,
    P0_TS1   = 4'd3,
    P0_TS2   = 4'd4,
    P0_SDS   = 4'd5,
    P0       = 4'd6,
    P0_EXIT  = 4'd7,
    P1       = 4'd8,
    P1_EXIT  = 4'd9
  } ltssm_state_t;

  // ------------------------------
  // Ordered set symbols
  localparam logic [7:0] TSX_BYTE0 = 8'hBC;  // Leads both TS1 and TS2
  localparam logic [7:0] TS1_BYTEX = 8'h4A;
  localparam logic [7:0] TS2_BYTEX = 8'h45;
  localparam logic [7:0] SDS_BYTE0 = 8'hE7;
  localparam logic [7:0] SDS_BYTEX = 8'h55;

  localparam int OS_LEN = 16;  // Bytes per ordered set

endpackage

// File: rtl/ltssm_config.svh
`ifndef LTSSM_CONFIG_SVH
`define LTSSM_CONFIG_SVH

// Link geometry
`define LTSSM_NUM_LANES   4
`define LTSSM_DATA_WIDTH  8   // 8 or 16 bits per lane per cycle

// Timers and count settings
`define LTSSM_COUNT_WIDTH 16

`endif
